//--- ctiQueue.f
source/ctiQueuePkg.sv
source/slotCompactor.sv
source/queuePointers.sv
source/entryStorage.sv
source/ctiQueue.sv
test/ctiQueueSva.sv
test/ctiQueueTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the CTI queue testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module ctiQueueTb \
	-f ctiQueue.f \
	--Mdir obj_dir -o ctiQueueSim

# The run continues past an assertion error so that the testbench reports the result.
./obj_dir/ctiQueueSim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
	echo "Simulation reported a failure."
	exit 1
fi
if ! grep -q "test passed" sim.log; then
	echo "Simulation ended without a result."
	exit 1
fi

//--- source/ctiQueue.sv
// Control-transfer-instruction queue top level: slot compactor, pointer unit and entry storage.
`timescale 1ns/1ps

module ctiQueue
(
	input logic clk,
	input logic reset,
	input logic recover_i,
	input logic stall_i,
	input logic fetchReady_i,
	input ctiQueuePkg::slotVector_t ctrlVector_i,
	input ctiQueuePkg::fetchSlot_t [ctiQueuePkg::FetchWidth-1:0] fetchSlots_i,
	output ctiQueuePkg::ctiTag_t [ctiQueuePkg::FetchWidth-1:0] ctiTags_o,
	input logic resolveValid_i,
	input ctiQueuePkg::ctiResolve_t resolve_i,
	input ctiQueuePkg::retireVector_t commitVector_i,
	output logic updateEn_o,
	output ctiQueuePkg::ctiUpdate_t update_o,
	output logic queueFull_o
);

	import ctiQueuePkg::*;

	ctiTag_t tailPtr;
	ctiTag_t headPtr;
	allocBundle_t bundle;
	writeCtl_t writeCtl;
	logic headCommitted;

	slotCompactor compactor
	(
		.ctrlVector_i(ctrlVector_i),
		.fetchSlots_i(fetchSlots_i),
		.tailPtr_i(tailPtr),
		.bundle_o(bundle),
		.ctiTags_o(ctiTags_o)
	);

	queuePointers pointers
	(
		.clk(clk),
		.reset(reset),
		.recover_i(recover_i),
		.stall_i(stall_i),
		.fetchReady_i(fetchReady_i),
		.allocCount_i(bundle.count),
		.resolveValid_i(resolveValid_i),
		.commitVector_i(commitVector_i),
		.headCommitted_i(headCommitted),
		.tailPtr_o(tailPtr),
		.headPtr_o(headPtr),
		.writeCtl_o(writeCtl),
		.updateEn_o(updateEn_o),
		.queueFull_o(queueFull_o)
	);

	entryStorage storage
	(
		.clk(clk),
		.reset(reset),
		.bundle_i(bundle),
		.resolve_i(resolve_i),
		.writeCtl_i(writeCtl),
		.headPtr_i(headPtr),
		.headCommitted_o(headCommitted),
		.update_o(update_o)
	);

endmodule

//--- source/ctiQueuePkg.sv
// Queue sizes, field types and the structs passed between the queue units.
package ctiQueuePkg;

	localparam int CtiQueueDepth = 16;
	localparam int CtiTagBits = 4;
	localparam int PcBits = 32;
	localparam int CtrlTypeBits = 2;
	localparam int FetchWidth = 4;
	localparam int RetireWidth = 4;

	typedef logic [CtiTagBits-1:0] ctiTag_t;
	typedef logic [CtiTagBits:0] ctiCount_t;   // Holds 0 up to a full queue.
	typedef logic [PcBits-1:0] pc_t;
	typedef logic [CtrlTypeBits-1:0] ctrlType_t;
	typedef logic [FetchWidth-1:0] slotVector_t;
	typedef logic [RetireWidth-1:0] retireVector_t;
	typedef logic [2:0] slotCount_t;           // 0 to 4 slots or commits.

	typedef struct packed {
		pc_t pc;
		ctrlType_t ctrlType;
	} fetchSlot_t;

	// Written back by execute.
	typedef struct packed {
		ctiTag_t tag;
		pc_t target;
		logic taken;
	} ctiResolve_t;

	typedef struct packed {
		pc_t pc;
		pc_t target;
		ctrlType_t ctrlType;
		logic taken;
	} ctiUpdate_t;

	typedef struct packed {
		fetchSlot_t [FetchWidth-1:0] slots;  // Valid slots packed from index 0.
		slotCount_t count;
	} allocBundle_t;

	typedef struct packed {
		logic allocEn;
		logic resolveEn;
		slotCount_t commitCount;
		ctiTag_t tailPtr;
		ctiTag_t commitPtr;
	} writeCtl_t;

endpackage

//--- source/entryStorage.sv
// Entry storage: static and resolved fields plus committed bits, with the head read port.
`timescale 1ns/1ps

module entryStorage
(
	input logic clk,
	input logic reset,
	input ctiQueuePkg::allocBundle_t bundle_i,
	input ctiQueuePkg::ctiResolve_t resolve_i,
	input ctiQueuePkg::writeCtl_t writeCtl_i,
	input ctiQueuePkg::ctiTag_t headPtr_i,
	output logic headCommitted_o,
	output ctiQueuePkg::ctiUpdate_t update_o
);

	import ctiQueuePkg::*;

	pc_t entryPc [CtiQueueDepth];
	ctrlType_t entryType [CtiQueueDepth];
	pc_t entryTarget [CtiQueueDepth];
	logic entryTaken [CtiQueueDepth];
	logic [CtiQueueDepth-1:0] committed;

	ctiTag_t allocIdx [FetchWidth];
	ctiTag_t commitIdx [RetireWidth];

	always_comb
	begin
		for (int k = 0; k < FetchWidth; k++)
			allocIdx[k] = writeCtl_i.tailPtr + ctiTag_t'(k);
		for (int k = 0; k < RetireWidth; k++)
			commitIdx[k] = writeCtl_i.commitPtr + ctiTag_t'(k);
	end

	// Static fields at allocation, resolved fields by tag.
	always_ff @(posedge clk)
	begin
		if (writeCtl_i.allocEn)
		begin
			for (int k = 0; k < FetchWidth; k++)
			begin
				if (slotCount_t'(k) < bundle_i.count)
				begin
					entryPc[allocIdx[k]] <= bundle_i.slots[k].pc;
					entryType[allocIdx[k]] <= bundle_i.slots[k].ctrlType;
				end
			end
		end
		if (writeCtl_i.resolveEn)
		begin
			entryTarget[resolve_i.tag] <= resolve_i.target;
			entryTaken[resolve_i.tag] <= resolve_i.taken;
		end
	end

	// New entries start uncommitted. Commits never touch the slots being allocated.
	always_ff @(posedge clk)
	begin
		if (reset)
			committed <= '0;
		else
		begin
			if (writeCtl_i.allocEn)
			begin
				for (int k = 0; k < FetchWidth; k++)
				begin
					if (slotCount_t'(k) < bundle_i.count)
						committed[allocIdx[k]] <= 1'b0;
				end
			end
			for (int k = 0; k < RetireWidth; k++)
			begin
				if (slotCount_t'(k) < writeCtl_i.commitCount)
					committed[commitIdx[k]] <= 1'b1;
			end
		end
	end

	assign headCommitted_o = committed[headPtr_i];

	always_comb
	begin
		update_o.pc = entryPc[headPtr_i];
		update_o.target = entryTarget[headPtr_i];
		update_o.ctrlType = entryType[headPtr_i];
		update_o.taken = entryTaken[headPtr_i];
	end

endmodule

//--- source/queuePointers.sv
// Queue pointer unit: head, tail and commit pointers, occupancy, full flag, drain and recovery.
`timescale 1ns/1ps

module queuePointers
(
	input logic clk,
	input logic reset,
	input logic recover_i,
	input logic stall_i,
	input logic fetchReady_i,
	input ctiQueuePkg::slotCount_t allocCount_i,
	input logic resolveValid_i,
	input ctiQueuePkg::retireVector_t commitVector_i,
	input logic headCommitted_i,
	output ctiQueuePkg::ctiTag_t tailPtr_o,
	output ctiQueuePkg::ctiTag_t headPtr_o,
	output ctiQueuePkg::writeCtl_t writeCtl_o,
	output logic updateEn_o,
	output logic queueFull_o
);

	import ctiQueuePkg::*;

	ctiTag_t headPtr;
	ctiTag_t tailPtr;
	ctiTag_t commitPtr;
	ctiCount_t occupancy;
	ctiCount_t freeSlots;
	ctiCount_t occupancyNext;
	ctiTag_t recoverCount;
	slotCount_t commitCount;
	logic accept;

	always_comb
	begin
		commitCount = '0;
		for (int i = 0; i < RetireWidth; i++)
			commitCount = commitCount + slotCount_t'(commitVector_i[i]);
	end

	assign freeSlots = ctiCount_t'(CtiQueueDepth) - occupancy;
	assign queueFull_o = ctiCount_t'(allocCount_i) > freeSlots;
	assign accept = fetchReady_i & ~stall_i & ~queueFull_o & ~recover_i;

	// Head entry leaves as a predictor update once it is committed.
	assign updateEn_o = headCommitted_i & (|occupancy) & ~recover_i;

	// Entries between head and commit pointer survive a recovery.
	assign recoverCount = commitPtr - headPtr;

	always_comb
	begin
		occupancyNext = occupancy;
		if (accept)
			occupancyNext = occupancyNext + ctiCount_t'(allocCount_i);
		if (updateEn_o)
			occupancyNext = occupancyNext - 5'd1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			headPtr <= '0;
			tailPtr <= '0;
			commitPtr <= '0;
			occupancy <= '0;
		end
		else
		begin
			if (updateEn_o)
				headPtr <= headPtr + 4'd1;
			commitPtr <= commitPtr + ctiTag_t'(commitCount);   // Advances even on recovery.
			if (recover_i)
			begin
				tailPtr <= commitPtr;
				occupancy <= ctiCount_t'(recoverCount);
			end
			else
			begin
				if (accept)
					tailPtr <= tailPtr + ctiTag_t'(allocCount_i);
				occupancy <= occupancyNext;
			end
		end
	end

	// Every storage write is gated here.
	always_comb
	begin
		writeCtl_o.allocEn = accept;
		writeCtl_o.resolveEn = resolveValid_i & ~recover_i;
		writeCtl_o.commitCount = recover_i ? 3'd0 : commitCount;
		writeCtl_o.tailPtr = tailPtr;
		writeCtl_o.commitPtr = commitPtr;
	end

	assign tailPtr_o = tailPtr;
	assign headPtr_o = headPtr;

endmodule

//--- source/slotCompactor.sv
// Slot compactor: packs the valid fetch slots in order and hands out their queue tags.
`timescale 1ns/1ps

module slotCompactor
(
	input ctiQueuePkg::slotVector_t ctrlVector_i,
	input ctiQueuePkg::fetchSlot_t [ctiQueuePkg::FetchWidth-1:0] fetchSlots_i,
	input ctiQueuePkg::ctiTag_t tailPtr_i,
	output ctiQueuePkg::allocBundle_t bundle_o,
	output ctiQueuePkg::ctiTag_t [ctiQueuePkg::FetchWidth-1:0] ctiTags_o
);

	import ctiQueuePkg::*;

	slotCount_t prefix [FetchWidth+1];   // Set bits below each slot.

	// Running count of control slots seen so far.
	always_comb
	begin
		prefix[0] = '0;
		for (int i = 0; i < FetchWidth; i++)
		begin
			if (ctrlVector_i[i])
				prefix[i+1] = prefix[i] + 3'd1;
			else
				prefix[i+1] = prefix[i];
		end
	end

	// Tags follow the tail; slots without a control instruction read zero.
	always_comb
	begin
		for (int i = 0; i < FetchWidth; i++)
		begin
			if (ctrlVector_i[i])
				ctiTags_o[i] = tailPtr_i + ctiTag_t'(prefix[i]);
			else
				ctiTags_o[i] = '0;
		end
	end

	always_comb
	begin
		bundle_o = '0;
		for (int i = 0; i < FetchWidth; i++)
		begin
			if (ctrlVector_i[i])
				bundle_o.slots[prefix[i]] = fetchSlots_i[i];   // Slot i lands at its rank.
		end
		bundle_o.count = prefix[FetchWidth];
	end

endmodule

//--- test/ctiQueueSva.sv
// Bound checks on the CTI queue ports: drain in recovery, unique tags, full flag, reset exit.
`timescale 1ns/1ps

module ctiQueueSva
(
	input logic clk,
	input logic reset,
	input logic recover_i,
	input ctiQueuePkg::slotVector_t ctrlVector_i,
	input ctiQueuePkg::ctiTag_t [ctiQueuePkg::FetchWidth-1:0] ctiTags_i,
	input logic updateEn_i,
	input logic queueFull_i
);

	import ctiQueuePkg::*;

	int failCount = 0;   // Failed assertions so far.

	function automatic logic tagsDistinct(input slotVector_t valid,
		input ctiTag_t [FetchWidth-1:0] tags);
		logic distinct;
		distinct = 1'b1;
		for (int i = 0; i < FetchWidth; i++)
		begin
			for (int j = i + 1; j < FetchWidth; j++)
			begin
				if (valid[i] && valid[j] && tags[i] == tags[j])
					distinct = 1'b0;
			end
		end
		return distinct;
	endfunction

	noDrainInRecovery: assert property (@(posedge clk) disable iff (reset)
		recover_i |-> !updateEn_i)
	else
	begin
		failCount++;
		$error("Update enable is high during a recovery.");
	end

	uniqueTags: assert property (@(posedge clk) disable iff (reset)
		tagsDistinct(ctrlVector_i, ctiTags_i))
	else
	begin
		failCount++;
		$error("Two valid fetch slots carry the same tag.");
	end

	// A bundle with no control slots always fits.
	fullNeedsSlots: assert property (@(posedge clk) disable iff (reset)
		queueFull_i |-> ctrlVector_i != '0)
	else
	begin
		failCount++;
		$error("Full flag is high for an empty slot vector.");
	end

	quietAfterReset: assert property (@(posedge clk)
		$fell(reset) |-> !updateEn_i && !queueFull_i)
	else
	begin
		failCount++;
		$error("A control output is high in the first cycle after reset.");
	end

endmodule

bind ctiQueue ctiQueueSva checks
(
	.clk(clk),
	.reset(reset),
	.recover_i(recover_i),
	.ctrlVector_i(ctrlVector_i),
	.ctiTags_i(ctiTags_o),
	.updateEn_i(updateEn_o),
	.queueFull_i(queueFull_o)
);

//--- test/ctiQueueTb.sv
// CTI queue testbench: clock, reset, LFSR stimulus, reference model, checks and timeout.
`timescale 1ns/1ps

module ctiQueueTb;

	import ctiQueuePkg::*;

	localparam int CycleLimit = 2000;
	localparam int FetchOff = 0;
	localparam int FetchRandom = 1;
	localparam int FetchForced = 2;
	localparam int RecoverOff = 0;
	localparam int RecoverRandom = 1;
	localparam int RecoverForced = 2;

	logic clk;
	logic reset;
	logic recover;
	logic stall;
	logic fetchReady;
	slotVector_t ctrlVector;
	fetchSlot_t [FetchWidth-1:0] fetchSlots;
	ctiTag_t [FetchWidth-1:0] ctiTags;
	logic resolveValid;
	ctiResolve_t resolve;
	retireVector_t commitVector;
	logic updateEn;
	ctiUpdate_t update;
	logic queueFull;

	pc_t modelPc [CtiQueueDepth];
	ctrlType_t modelType [CtiQueueDepth];
	pc_t modelTarget [CtiQueueDepth];
	logic modelTaken [CtiQueueDepth];
	logic modelResolved [CtiQueueDepth];
	int head;
	int tail;
	int commitIdx;
	int occ;
	int committedCount;   // Committed but not yet drained.
	logic [31:0] lfsr;
	int cycles = 0;

	ctiQueue DUT
	(
		.clk(clk),
		.reset(reset),
		.recover_i(recover),
		.stall_i(stall),
		.fetchReady_i(fetchReady),
		.ctrlVector_i(ctrlVector),
		.fetchSlots_i(fetchSlots),
		.ctiTags_o(ctiTags),
		.resolveValid_i(resolveValid),
		.resolve_i(resolve),
		.commitVector_i(commitVector),
		.updateEn_o(updateEn),
		.update_o(update),
		.queueFull_o(queueFull)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit)
			abortRun("Timeout: the run did not finish within the cycle limit.");
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "Simulation stopped.");
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAILED at %0t: %s expected 0x%0h, actual 0x%0h", $time, name, expected, actual);
		abortRun("Output differs from the reference model.");
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 that steps once per bit.
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic int countBits(input logic [3:0] bits);
		int n;
		n = 0;
		for (int i = 0; i < 4; i++)
			n = n + (bits[i] ? 1 : 0);
		return n;
	endfunction

	function automatic logic expectFull();
		return countBits(ctrlVector) > CtiQueueDepth - occ;
	endfunction

	function automatic logic expectDrain();
		return committedCount > 0 && occ > 0 && !recover;
	endfunction

	task automatic driveInputs(input int fetchMode, input logic work, input int recoverMode);
		int open;
		int ready;
		retireVector_t vec;
		recover = (recoverMode == RecoverForced);
		if (recoverMode == RecoverRandom)
			recover = takeBits(5) == 0;   // Roughly one cycle in 32.
		stall = (fetchMode == FetchRandom) ? takeBits(3) == 0 : 1'b0;
		fetchReady = (fetchMode == FetchForced) || (fetchMode == FetchRandom && takeBits(3) != 0);
		ctrlVector = slotVector_t'(takeBits(4));
		for (int i = 0; i < FetchWidth; i++)
		begin
			fetchSlots[i].pc = takeBits(32);
			fetchSlots[i].ctrlType = ctrlType_t'(takeBits(2));
		end
		open = occ - committedCount;
		resolveValid = 1'b0;
		resolve = '0;
		commitVector = '0;
		if (work && !recover && open > 0 && takeBits(1) == 1)
		begin
			resolveValid = 1'b1;   // Only uncommitted entries resolve.
			resolve.tag = ctiTag_t'(commitIdx + int'(takeBits(4)) % open);
			resolve.target = takeBits(32);
			resolve.taken = 1'(takeBits(1));
		end
		else if (work && recover && committedCount > 0 && takeBits(1) == 1)
		begin
			resolveValid = 1'b1;   // Aimed at a committed entry that recovery keeps.
			resolve.tag = ctiTag_t'(head + int'(takeBits(4)) % committedCount);
			resolve.target = takeBits(32);
			resolve.taken = 1'(takeBits(1));
		end
		// Commits take resolved entries in order from the commit pointer.
		ready = 0;
		while (ready < open && ready < RetireWidth
			&& modelResolved[(commitIdx + ready) % CtiQueueDepth])
			ready++;
		if (work && !recover)
		begin
			vec = retireVector_t'(takeBits(4));
			for (int i = RetireWidth - 1; i >= 0; i--)
			begin
				if (countBits(vec) > ready)
					vec[i] = 1'b0;
			end
			commitVector = vec;
		end
	endtask

	task automatic checkOutputs();
		ctiTag_t expTag;
		int rank;
		rank = 0;
		for (int i = 0; i < FetchWidth; i++)
		begin
			expTag = '0;
			if (ctrlVector[i])
			begin
				expTag = ctiTag_t'(tail + rank);
				rank++;
			end
			assert (ctiTags[i] == expTag)
			else reportMismatch($sformatf("ctiTags_o[%0d]", i), 32'(expTag), 32'(ctiTags[i]));
		end
		assert (queueFull == expectFull())
		else reportMismatch("queueFull_o", 32'(expectFull()), 32'(queueFull));
		assert (updateEn == expectDrain())
		else reportMismatch("updateEn_o", 32'(expectDrain()), 32'(updateEn));
		if (expectDrain())
		begin
			assert (update.pc == modelPc[head])
			else reportMismatch("update_o.pc", modelPc[head], update.pc);
			assert (update.ctrlType == modelType[head])
			else reportMismatch("update_o.ctrlType", 32'(modelType[head]), 32'(update.ctrlType));
			assert (update.target == modelTarget[head])
			else reportMismatch("update_o.target", modelTarget[head], update.target);
			assert (update.taken == modelTaken[head])
			else reportMismatch("update_o.taken", 32'(modelTaken[head]), 32'(update.taken));
		end
		if (DUT.checks.failCount != 0)
			abortRun("A bound assertion on the queue ports failed.");
	endtask

	// Moves the model across one rising edge.
	task automatic advanceModel();
		logic accept;
		logic drain;
		accept = fetchReady && !stall && !expectFull() && !recover;
		drain = expectDrain();
		if (recover)
		begin
			tail = commitIdx;
			occ = (commitIdx - head + CtiQueueDepth) % CtiQueueDepth;
			committedCount = occ;   // Only committed entries survive.
		end
		else
		begin
			if (resolveValid)
			begin
				modelTarget[resolve.tag] = resolve.target;
				modelTaken[resolve.tag] = resolve.taken;
				modelResolved[resolve.tag] = 1'b1;
			end
			commitIdx = (commitIdx + countBits(commitVector)) % CtiQueueDepth;
			committedCount = committedCount + countBits(commitVector);
			for (int i = 0; i < FetchWidth; i++)
			begin
				if (accept && ctrlVector[i])
				begin
					modelPc[tail] = fetchSlots[i].pc;
					modelType[tail] = fetchSlots[i].ctrlType;
					modelResolved[tail] = 1'b0;
					tail = (tail + 1) % CtiQueueDepth;
					occ++;
				end
			end
			if (drain)
			begin
				head = (head + 1) % CtiQueueDepth;
				occ--;
				committedCount--;
			end
		end
	endtask

	task automatic runCycle(input int fetchMode, input logic work, input int recoverMode);
		@(negedge clk);
		driveInputs(fetchMode, work, recoverMode);
		#2;
		checkOutputs();
		advanceModel();
	endtask

	initial
	begin
		lfsr = 32'h1fdc4791;
		reset = 1'b1;
		recover = 1'b0;
		stall = 1'b0;
		fetchReady = 1'b0;
		ctrlVector = '0;
		fetchSlots = '0;
		resolveValid = 1'b0;
		resolve = '0;
		commitVector = '0;
		head = 0;
		tail = 0;
		commitIdx = 0;
		occ = 0;
		committedCount = 0;
		for (int i = 0; i < CtiQueueDepth; i++)
			modelResolved[i] = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#2;
		checkOutputs();   // Empty vector right after reset.
		advanceModel();
		repeat (500) runCycle(FetchRandom, 1'b1, RecoverRandom);
		// Fill with no commits so that bundles hit the full flag.
		repeat (40) runCycle(FetchForced, 1'b0, RecoverOff);
		repeat (12) runCycle(FetchOff, 1'b1, RecoverOff);
		runCycle(FetchOff, 1'b1, RecoverForced);
		repeat (150) runCycle(FetchRandom, 1'b1, RecoverRandom);
		repeat (80) runCycle(FetchOff, 1'b1, RecoverOff);
		@(negedge clk);
		if (DUT.checks.failCount == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
			abortRun("A bound assertion on the queue ports failed.");
	end

endmodule
